//--- sim/tb_pong_display.sv
`timescale 1ns/10ps
`include "pong_consts.svh"

module tb_pong_display;

    localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;
    localparam int TEST_FRAMES  = 12;    // The tests take a little under 11 frames
    localparam int WATCHDOG_NS  = TEST_FRAMES * FRAME_CYCLES * 40;
    localparam int ACK_LIMIT    = 8;
    localparam int SEL_HSYNC    = 0;
    localparam int SEL_VSYNC    = 1;
    localparam int SEL_DE       = 2;

    // Each entry is {x, y, expected colour} in raster order for the first frame
    localparam logic [31:0] RESET_SAMPLES [24] = '{
        {10'd318, 10'd0,   12'hFFF}, {10'd322, 10'd0,   12'h000}, {10'd321, 10'd15,  12'hFFF},
        {10'd279, 10'd16,  12'h000}, {10'd280, 10'd16,  12'h888}, {10'd318, 10'd16,  12'h000},
        {10'd336, 10'd16,  12'h888}, {10'd288, 10'd32,  12'h000}, {10'd359, 10'd40,  12'h888},
        {10'd303, 10'd55,  12'h888}, {10'd304, 10'd55,  12'h000}, {10'd16,  10'd208, 12'hFFF},
        {10'd616, 10'd208, 12'hFFF}, {10'd316, 10'd236, 12'hFFF}, {10'd15,  10'd240, 12'h000},
        {10'd24,  10'd240, 12'h000}, {10'd315, 10'd240, 12'h000}, {10'd324, 10'd240, 12'h000},
        {10'd624, 10'd240, 12'h000}, {10'd316, 10'd243, 12'hFFF}, {10'd316, 10'd244, 12'h000},
        {10'd23,  10'd271, 12'hFFF}, {10'd623, 10'd271, 12'hFFF}, {10'd16,  10'd272, 12'h000}
    };

    logic                clk_i;
    logic                rst_i;
    logic                req_i;
    pong_pkg::reg_addr_e addr_i;
    logic [11:0]         data_i;
    logic                ack_o;
    pong_pkg::rgb_t      rgb_o;
    logic                de_o;
    logic                hsync_o;
    logic                vsync_o;
    logic                new_frame_o;

    // Reference copy of the registers as written by the host and shown per frame
    pong_pkg::coord_t sh_x [`N_SPRITES];
    pong_pkg::coord_t sh_y [`N_SPRITES];
    pong_pkg::rgb_t   sh_rgb [`N_SPRITES];
    logic             sh_en [`N_SPRITES];
    pong_pkg::digit_t sh_score_l;
    pong_pkg::digit_t sh_score_r;
    pong_pkg::coord_t lv_x [`N_SPRITES];
    pong_pkg::coord_t lv_y [`N_SPRITES];
    pong_pkg::rgb_t   lv_rgb [`N_SPRITES];
    logic             lv_en [`N_SPRITES];
    pong_pkg::digit_t lv_score_l;
    pong_pkg::digit_t lv_score_r;

    int             trk_x;
    int             trk_y;
    int             pix_x;
    int             pix_y;
    int             frame_pixels;
    int             frame_no;
    logic           de_prev;
    pong_pkg::rgb_t exp_rgb;
    string          cur_test;
    event           pixel_ev;
    event           frame_ev;

    pong_display_top u_pong_display_top (
        .clk_i       ( clk_i       ),
        .rst_i       ( rst_i       ),
        .req_i       ( req_i       ),
        .addr_i      ( addr_i      ),
        .data_i      ( data_i      ),
        .ack_o       ( ack_o       ),
        .rgb_o       ( rgb_o       ),
        .de_o        ( de_o        ),
        .hsync_o     ( hsync_o     ),
        .vsync_o     ( vsync_o     ),
        .new_frame_o ( new_frame_o )
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    initial begin
        #(WATCHDOG_NS);
        stop_on_error("Watchdog expired before the tests finished");
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_rgb(input string what, input pong_pkg::rgb_t exp,
                             input pong_pkg::rgb_t act);
        if (exp !== act)
            stop_on_error($sformatf("Mismatch in %s (%s): expected 12'h%h, actual 12'h%h",
                                    cur_test, what, exp, act));
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (exp !== act)
            stop_on_error($sformatf("Mismatch in %s (%s): expected %b, actual %b",
                                    cur_test, what, exp, act));
    endtask

    task automatic check_count(input string what, input int exp, input int act);
        if (exp != act)
            stop_on_error($sformatf("Mismatch in %s (%s): expected %0d, actual %0d",
                                    cur_test, what, exp, act));
    endtask

    // Rows 0..4 from the top with three cells per row and column 0 leftmost
    function automatic logic [14:0] digit_cells(input pong_pkg::digit_t d);
        case (d)
            4'd0:    return 15'b111_101_101_101_111;
            4'd1:    return 15'b001_001_001_001_001;
            4'd2:    return 15'b111_001_111_100_111;
            4'd3:    return 15'b111_001_111_001_111;
            4'd4:    return 15'b101_101_111_001_001;
            4'd5:    return 15'b111_100_111_001_111;
            4'd6:    return 15'b111_100_111_101_111;
            4'd7:    return 15'b111_001_001_001_001;
            4'd8:    return 15'b111_101_111_101_111;
            4'd9:    return 15'b111_101_111_001_111;
            default: return 15'b0;
        endcase
    endfunction

    function automatic logic cell_lit(input int dx, input int dy, input pong_pkg::digit_t d);
        logic [14:0] cells;
        cells = digit_cells(d);
        if (dx < 0 || dx >= 3 * `SEG_SCALE || dy < 0 || dy >= 5 * `SEG_SCALE)
            return 1'b0;
        return cells[14 - ((dy / `SEG_SCALE) * 3 + dx / `SEG_SCALE)];
    endfunction

    function automatic pong_pkg::rgb_t expected_pixel(input int x, input int y);
        pong_pkg::rgb_t c;
        int             s;
        int             w;
        int             h;
        c = '0;
        if (cell_lit(x - `SCORE_L_X, y - `SCORE_Y, lv_score_l) ||
            cell_lit(x - `SCORE_R_X, y - `SCORE_Y, lv_score_r))
            c = `SCORE_RGB;
        for (s = 0; s < `N_SPRITES; s++) begin
            w = (s == 2) ? `BALL_SIDE : `PADDLE_W;
            h = (s == 2) ? `BALL_SIDE : `PADDLE_H;
            if (lv_en[s] && x >= int'(lv_x[s]) && x < int'(lv_x[s]) + w &&
                y >= int'(lv_y[s]) && y < int'(lv_y[s]) + h)
                c = lv_rgb[s];    // Higher index lands on top
        end
        if (x >= `SEP_X0 && x < `SEP_X0 + `SEP_W && (y % `SEP_PERIOD) < `SEP_DOT_H)
            c = `WHITE_RGB;
        return c;
    endfunction

    function automatic pong_pkg::digit_t clamp_score(input logic [11:0] data);
        return (data > 12'd9) ? 4'd9 : data[3:0];
    endfunction

    task automatic mirror_reset();
        sh_x       = '{`LPAD_X0, `RPAD_X0, `BALL_X0};
        sh_y       = '{`LPAD_Y0, `RPAD_Y0, `BALL_Y0};
        sh_rgb     = '{`SPRITE_RGB, `SPRITE_RGB, `SPRITE_RGB};
        sh_en      = '{1'b1, 1'b1, 1'b1};
        sh_score_l = '0;
        sh_score_r = '0;
        lv_x       = sh_x;
        lv_y       = sh_y;
        lv_rgb     = sh_rgb;
        lv_en      = sh_en;
        lv_score_l = '0;
        lv_score_r = '0;
    endtask

    task automatic mirror_write(input pong_pkg::reg_addr_e addr, input logic [11:0] data);
        int a;
        a = int'(addr);
        if (a < 12) begin
            case (a % 4)
                0: sh_x[a / 4] = data[9:0];
                1: sh_y[a / 4] = data[9:0];
                2: sh_rgb[a / 4] = data;
                default: sh_en[a / 4] = data[0];
            endcase
        end else if (a == 12) begin
            sh_score_l = clamp_score(data);
        end else if (a == 13) begin
            sh_score_r = clamp_score(data);
        end
    endtask

    // Follows the displayed raster and compares every visible pixel
    always @(negedge clk_i) begin
        if (rst_i) begin
            trk_x        = 0;
            trk_y        = 0;
            de_prev      = 1'b0;
            frame_pixels = 0;
        end else begin
            if (de_o) begin
                pix_x   = trk_x;
                pix_y   = trk_y;
                exp_rgb = expected_pixel(pix_x, pix_y);
                if (rgb_o !== exp_rgb)
                    check_rgb($sformatf("frame %0d pixel (%0d,%0d)", frame_no, pix_x, pix_y),
                              exp_rgb, rgb_o);
                frame_pixels++;
                trk_x++;
                -> pixel_ev;
            end else if (de_prev) begin
                trk_x = 0;
                trk_y++;
            end
            if (new_frame_o) begin
                check_count($sformatf("pixels in frame %0d", frame_no),
                            `H_VISIBLE * `V_VISIBLE, frame_pixels);
                frame_pixels = 0;
                trk_y        = 0;
                lv_x         = sh_x;    // Shadow becomes live at the frame boundary
                lv_y         = sh_y;
                lv_rgb       = sh_rgb;
                lv_en        = sh_en;
                lv_score_l   = sh_score_l;
                lv_score_r   = sh_score_r;
                frame_no++;
                -> frame_ev;
            end
            de_prev = de_o;
        end
    end

    task automatic write_reg(input pong_pkg::reg_addr_e addr, input logic [11:0] data);
        int waited;
        @(negedge clk_i);
        req_i  = 1'b1;
        addr_i = addr;
        data_i = data;
        waited = 0;
        while (ack_o !== 1'b1) begin
            if (waited == ACK_LIMIT)
                stop_on_error("Host write got no ack_o within 8 cycles of raising req_i");
            @(negedge clk_i);
            waited++;
        end
        mirror_write(addr, data);
        req_i  = 1'b0;
        waited = 0;
        while (ack_o !== 1'b0) begin
            if (waited == ACK_LIMIT)
                stop_on_error("ack_o stayed high for 8 cycles after req_i was dropped");
            @(negedge clk_i);
            waited++;
        end
    endtask

    task automatic wait_pixel(input int x, input int y);
        do
            @(pixel_ev);
        while (pix_x != x || pix_y != y);
    endtask

    // Halfway down the next frame and far from any frame boundary
    task automatic wait_mid_frame();
        @(frame_ev);
        wait_pixel(0, `V_VISIBLE / 2);
    endtask

    function automatic logic line_level(input int sel);
        case (sel)
            SEL_HSYNC: return hsync_o;
            SEL_VSYNC: return vsync_o;
            default:   return de_o;
        endcase
    endfunction

    task automatic measure_pulse(input int sel, output int low_len, output int period);
        int n;
        while (line_level(sel) == 1'b0) @(negedge clk_i);
        while (line_level(sel) == 1'b1) @(negedge clk_i);
        n = 0;
        while (line_level(sel) == 1'b0) begin
            @(negedge clk_i);
            n++;
        end
        low_len = n;
        while (line_level(sel) == 1'b1) begin
            @(negedge clk_i);
            n++;
        end
        period = n;
    endtask

    // Cycles from now until the chosen line reaches the given level
    task automatic count_until(input int sel, input logic level, output int cycles);
        int n;
        n = 0;
        while (line_level(sel) !== level) begin
            @(negedge clk_i);
            n++;
        end
        cycles = n;
    endtask

    task automatic reset_outputs_test();
        cur_test = "reset values";
        check_bit("ack_o", 1'b0, ack_o);
        check_bit("new_frame_o", 1'b0, new_frame_o);
        check_bit("de_o", 1'b0, de_o);
        check_bit("hsync_o", 1'b1, hsync_o);
        check_bit("vsync_o", 1'b1, vsync_o);
        check_rgb("rgb_o", 12'h000, rgb_o);
    endtask

    task automatic reset_frame_test();
        int i;
        int x;
        int y;
        cur_test = "reset frame";
        for (i = 0; i < 24; i++) begin
            x = RESET_SAMPLES[i][31:22];
            y = RESET_SAMPLES[i][21:12];
            wait_pixel(x, y);
            check_rgb($sformatf("sample (%0d,%0d)", x, y), RESET_SAMPLES[i][11:0], rgb_o);
        end
    endtask

    task automatic sync_timing_test();
        int low_len;
        int period;
        int lag;
        cur_test = "sync timing";
        measure_pulse(SEL_HSYNC, low_len, period);
        check_count("hsync low cycles", `H_SYNC, low_len);
        check_count("hsync period", `H_TOTAL, period);
        measure_pulse(SEL_DE, low_len, period);
        check_count("de_o cycles per line", `H_VISIBLE, period - low_len);
        count_until(SEL_HSYNC, 1'b0, lag);
        check_count("de_o fall to hsync_o fall", `H_FRONT, lag);
        measure_pulse(SEL_VSYNC, low_len, period);
        check_count("vsync low cycles", `V_SYNC * `H_TOTAL, low_len);
        check_count("vsync period", FRAME_CYCLES, period);
        count_until(SEL_HSYNC, 1'b0, lag);
        check_count("vsync_o fall to hsync_o fall", `H_VISIBLE + `H_FRONT, lag);
    endtask

    // The rest of the current frame must still match the old ball position
    task automatic frame_update_test();
        int i;
        int bx;
        int by;
        for (i = 0; i < 3; i++) begin
            wait_mid_frame();
            cur_test = $sformatf("frame update %0d", i);
            bx = $urandom % (`H_VISIBLE - `BALL_SIDE + 1);
            by = $urandom % (`V_VISIBLE - `BALL_SIDE + 1);
            write_reg(pong_pkg::ADDR_S2_X, 12'(bx));
            write_reg(pong_pkg::ADDR_S2_Y, 12'(by));
        end
    endtask

    task automatic priority_enable_test();
        wait_mid_frame();
        cur_test = "ball over paddle";
        write_reg(pong_pkg::ADDR_S2_COLOR, 12'hF00);
        write_reg(pong_pkg::ADDR_S2_X, 12'd20);
        write_reg(pong_pkg::ADDR_S2_Y, 12'd230);
        wait_mid_frame();
        cur_test = "ball over separator";
        write_reg(pong_pkg::ADDR_S2_X, 12'd316);
        write_reg(pong_pkg::ADDR_S2_Y, 12'd100);
        wait_mid_frame();
        cur_test = "paddle over score";
        write_reg(pong_pkg::ADDR_S1_COLOR, 12'h0F0);
        write_reg(pong_pkg::ADDR_S1_X, 12'd284);
        write_reg(pong_pkg::ADDR_S1_Y, 12'd20);
        wait_mid_frame();
        cur_test = "left paddle disabled";
        write_reg(pong_pkg::ADDR_S0_EN, 12'd0);
    endtask

    task automatic score_handshake_test();
        wait_mid_frame();
        cur_test = "scores and handshake";
        write_reg(pong_pkg::ADDR_SCORE_L, 12'd7);
        write_reg(pong_pkg::ADDR_SCORE_R, 12'd12);
        write_reg(pong_pkg::reg_addr_e'(4'd14), 12'h005);
        @(negedge clk_i);
        check_bit("ack_o idle after writes", 1'b0, ack_o);
        @(frame_ev);
        wait_pixel(280, 32);
        check_rgb("left digit 7, row 2 column 0", 12'h000, rgb_o);
        wait_pixel(296, 32);
        check_rgb("left digit 7, row 2 column 2", `SCORE_RGB, rgb_o);
        wait_pixel(336, 32);
        check_rgb("right digit 9, row 2 column 0", `SCORE_RGB, rgb_o);
        @(frame_ev);    // Lets the pixel checker cover the whole frame
    endtask

    initial begin
        void'($urandom(32'h3585));
        rst_i     = 1'b1;
        req_i     = 1'b0;
        addr_i    = pong_pkg::ADDR_S0_X;
        data_i    = '0;
        frame_no  = 0;
        cur_test  = "reset";
        mirror_reset();
        repeat (3) @(negedge clk_i);
        reset_outputs_test();
        rst_i = 1'b0;
        reset_frame_test();
        sync_timing_test();
        frame_update_test();
        priority_enable_test();
        score_handshake_test();
        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- source/frame_compositor.sv
`timescale 1ns/10ps
`include "pong_consts.svh"

module frame_compositor (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  pong_pkg::coord_t       pixel_x_i,
    input  pong_pkg::coord_t       pixel_y_i,
    input  logic                   visible_i,
    input  logic                   hsync_i,
    input  logic                   vsync_i,
    input  logic [`N_SPRITES-1:0]  on_sprite_i,
    input  pong_pkg::rgb_t         sprite_rgb_i [`N_SPRITES],
    input  logic                   on_score_i,
    output pong_pkg::rgb_t         rgb_o,
    output logic                   de_o,
    output logic                   hsync_o,
    output logic                   vsync_o,
    output logic                   new_frame_o
);

    pong_pkg::coord_t x_d1;
    pong_pkg::coord_t y_d1;
    logic             visible_d1;
    logic             hsync_d1;
    logic             vsync_d1;
    logic             on_sep;
    pong_pkg::rgb_t   rgb_next;

    always_ff @(posedge clk_i) begin
        x_d1 <= pixel_x_i;
        y_d1 <= pixel_y_i;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            visible_d1 <= 1'b0;
            hsync_d1   <= 1'b1;
            vsync_d1   <= 1'b1;
        end else begin
            visible_d1 <= visible_i;
            hsync_d1   <= hsync_i;
            vsync_d1   <= vsync_i;
        end
    end

    assign on_sep = x_d1 >= `SEP_X0 && x_d1 < `SEP_X0 + `SEP_W &&
                    (y_d1 % `SEP_PERIOD) < `SEP_DOT_H;

    // Later assignments win, so the order below is the stacking order
    always_comb begin
        rgb_next = '0;
        if (on_score_i)
            rgb_next = `SCORE_RGB;
        for (int n = 0; n < `N_SPRITES; n++) begin
            if (on_sprite_i[n])
                rgb_next = sprite_rgb_i[n];
        end
        if (on_sep)
            rgb_next = `WHITE_RGB;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rgb_o       <= '0;
            de_o        <= 1'b0;
            hsync_o     <= 1'b1;
            vsync_o     <= 1'b1;
            new_frame_o <= 1'b0;
        end else begin
            rgb_o       <= visible_d1 ? rgb_next : '0;
            de_o        <= visible_d1;
            hsync_o     <= hsync_d1;
            vsync_o     <= vsync_d1;
            new_frame_o <= vsync_d1 && !vsync_o;    // vsync_o still holds the previous level
        end
    end

endmodule

//--- source/pong_consts.svh
`ifndef PONG_CONSTS_SVH
`define PONG_CONSTS_SVH

// 640x480 at 60 Hz, 25 MHz pixel clock
`define H_VISIBLE   640
`define H_FRONT     16
`define H_SYNC      96
`define H_BACK      48
`define H_TOTAL     800

`define V_VISIBLE   480
`define V_FRONT     10
`define V_SYNC      2
`define V_BACK      33
`define V_TOTAL     525

`define N_SPRITES   3
`define PADDLE_W    8
`define PADDLE_H    64
`define BALL_SIDE   8

`define SEP_X0      318
`define SEP_W       4
`define SEP_PERIOD  32
`define SEP_DOT_H   16

`define SCORE_L_X   280
`define SCORE_R_X   336
`define SCORE_Y     16
`define SEG_SCALE   8      // Pixels per cell of the 3x5 digit grid

`define LPAD_X0     10'd16
`define LPAD_Y0     10'd208
`define RPAD_X0     10'd616
`define RPAD_Y0     10'd208
`define BALL_X0     10'd316
`define BALL_Y0     10'd236

`define SPRITE_RGB  12'hFFF
`define WHITE_RGB   12'hFFF
`define SCORE_RGB   12'h888

`endif

//--- source/pong_display_top.sv
`timescale 1ns/10ps
`include "pong_consts.svh"

module pong_display_top (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                req_i,
    input  pong_pkg::reg_addr_e addr_i,
    input  logic [11:0]         data_i,
    output logic                ack_o,
    output pong_pkg::rgb_t      rgb_o,
    output logic                de_o,
    output logic                hsync_o,
    output logic                vsync_o,
    output logic                new_frame_o
);

    pong_pkg::coord_t      pixel_x;
    pong_pkg::coord_t      pixel_y;
    logic                  hsync;
    logic                  vsync;
    logic                  visible;
    logic [`N_SPRITES-1:0] on_sprite;
    pong_pkg::rgb_t        sprite_rgb [`N_SPRITES];
    pong_pkg::digit_t      score_l;
    pong_pkg::digit_t      score_r;
    logic                  on_score;

    sprite_if sprite_bus [`N_SPRITES] ();

    vga_timing u_vga_timing (
        .clk_i     ( clk_i   ),
        .rst_i     ( rst_i   ),
        .pixel_x_o ( pixel_x ),
        .pixel_y_o ( pixel_y ),
        .hsync_o   ( hsync   ),
        .vsync_o   ( vsync   ),
        .visible_o ( visible )
    );

    sprite_regs u_sprite_regs (
        .clk_i       ( clk_i       ),
        .rst_i       ( rst_i       ),
        .req_i       ( req_i       ),
        .addr_i      ( addr_i      ),
        .data_i      ( data_i      ),
        .new_frame_i ( new_frame_o ),
        .ack_o       ( ack_o       ),
        .sprites_o   ( sprite_bus  ),
        .score_l_o   ( score_l     ),
        .score_r_o   ( score_r     )
    );

    // Sprites 0 and 1 are the paddles, sprite 2 is the ball
    for (genvar i = 0; i < `N_SPRITES; i++) begin : g_sprite
        sprite_display #(
            .WIDTH  ( (i == 2) ? `BALL_SIDE : `PADDLE_W ),
            .HEIGHT ( (i == 2) ? `BALL_SIDE : `PADDLE_H )
        ) u_sprite_display (
            .clk_i         ( clk_i         ),
            .rst_i         ( rst_i         ),
            .pixel_x_i     ( pixel_x       ),
            .pixel_y_i     ( pixel_y       ),
            .sprite_i      ( sprite_bus[i] ),
            .on_sprite_o   ( on_sprite[i]  ),
            .display_rgb_o ( sprite_rgb[i] )
        );
    end

    score_display u_score_display (
        .clk_i      ( clk_i    ),
        .rst_i      ( rst_i    ),
        .pixel_x_i  ( pixel_x  ),
        .pixel_y_i  ( pixel_y  ),
        .score_l_i  ( score_l  ),
        .score_r_i  ( score_r  ),
        .on_score_o ( on_score )
    );

    frame_compositor u_frame_compositor (
        .clk_i        ( clk_i       ),
        .rst_i        ( rst_i       ),
        .pixel_x_i    ( pixel_x     ),
        .pixel_y_i    ( pixel_y     ),
        .visible_i    ( visible     ),
        .hsync_i      ( hsync       ),
        .vsync_i      ( vsync       ),
        .on_sprite_i  ( on_sprite   ),
        .sprite_rgb_i ( sprite_rgb  ),
        .on_score_i   ( on_score    ),
        .rgb_o        ( rgb_o       ),
        .de_o         ( de_o        ),
        .hsync_o      ( hsync_o     ),
        .vsync_o      ( vsync_o     ),
        .new_frame_o  ( new_frame_o )
    );

endmodule

//--- source/pong_pkg.sv
package pong_pkg;

    typedef logic [9:0]  coord_t;
    typedef logic [11:0] rgb_t;    // Red in the top nibble, blue in the bottom one
    typedef logic [3:0]  digit_t;

    // Four registers per sprite, so addr[3:2] is the sprite index below code 12
    typedef enum logic [3:0] {
        ADDR_S0_X     = 4'd0,
        ADDR_S0_Y     = 4'd1,
        ADDR_S0_COLOR = 4'd2,
        ADDR_S0_EN    = 4'd3,
        ADDR_S1_X     = 4'd4,
        ADDR_S1_Y     = 4'd5,
        ADDR_S1_COLOR = 4'd6,
        ADDR_S1_EN    = 4'd7,
        ADDR_S2_X     = 4'd8,
        ADDR_S2_Y     = 4'd9,
        ADDR_S2_COLOR = 4'd10,
        ADDR_S2_EN    = 4'd11,
        ADDR_SCORE_L  = 4'd12,
        ADDR_SCORE_R  = 4'd13
    } reg_addr_e;

    typedef enum logic {
        HS_IDLE,
        HS_ACK
    } hs_state_e;

endpackage

//--- source/score_display.sv
`timescale 1ns/10ps
`include "pong_consts.svh"

module score_display (
    input  logic             clk_i,
    input  logic             rst_i,
    input  pong_pkg::coord_t pixel_x_i,
    input  pong_pkg::coord_t pixel_y_i,
    input  pong_pkg::digit_t score_l_i,
    input  pong_pkg::digit_t score_r_i,
    output logic             on_score_o
);

    pong_pkg::coord_t dx_l;
    pong_pkg::coord_t dx_r;
    pong_pkg::coord_t dy;
    logic [1:0]       col;
    logic [2:0]       row;
    logic             in_l;
    logic             in_r;
    logic             in_y;
    logic [6:0]       seg;
    logic             lit;

    // Segment bits are g f e d c b a, with a on top and g in the middle
    function automatic logic [6:0] seg_pattern(input pong_pkg::digit_t d);
        case (d)
            4'd0:    return 7'b0111111;
            4'd1:    return 7'b0000110;
            4'd2:    return 7'b1011011;
            4'd3:    return 7'b1001111;
            4'd4:    return 7'b1100110;
            4'd5:    return 7'b1101101;
            4'd6:    return 7'b1111101;
            4'd7:    return 7'b0000111;
            4'd8:    return 7'b1111111;
            4'd9:    return 7'b1101111;
            default: return 7'b0000000;
        endcase
    endfunction

    assign dx_l = pixel_x_i - pong_pkg::coord_t'(`SCORE_L_X);
    assign dx_r = pixel_x_i - pong_pkg::coord_t'(`SCORE_R_X);
    assign dy   = pixel_y_i - pong_pkg::coord_t'(`SCORE_Y);

    assign in_l = pixel_x_i >= `SCORE_L_X && pixel_x_i < `SCORE_L_X + 3 * `SEG_SCALE;
    assign in_r = pixel_x_i >= `SCORE_R_X && pixel_x_i < `SCORE_R_X + 3 * `SEG_SCALE;
    assign in_y = pixel_y_i >= `SCORE_Y && pixel_y_i < `SCORE_Y + 5 * `SEG_SCALE;

    assign row = 3'(dy / `SEG_SCALE);

    always_comb begin
        seg = 7'b0;
        col = 2'd0;
        if (in_l) begin
            seg = seg_pattern(score_l_i);
            col = 2'(dx_l / `SEG_SCALE);
        end else if (in_r) begin
            seg = seg_pattern(score_r_i);
            col = 2'(dx_r / `SEG_SCALE);
        end
    end

    // Verticals share the cell of row 2 with the middle bar
    assign lit = (seg[0] && row == 3'd0) ||
                 (seg[6] && row == 3'd2) ||
                 (seg[3] && row == 3'd4) ||
                 (seg[5] && col == 2'd0 && row <= 3'd2) ||
                 (seg[1] && col == 2'd2 && row <= 3'd2) ||
                 (seg[4] && col == 2'd0 && row >= 3'd2) ||
                 (seg[2] && col == 2'd2 && row >= 3'd2);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            on_score_o <= 1'b0;
        end else begin
            on_score_o <= in_y && lit;
        end
    end

endmodule

//--- source/sprite_display.sv
`timescale 1ns/10ps
`include "pong_consts.svh"

module sprite_display #(
    parameter int WIDTH  = `PADDLE_W,
    parameter int HEIGHT = `PADDLE_H
) (
    input  logic             clk_i,
    input  logic             rst_i,
    input  pong_pkg::coord_t pixel_x_i,
    input  pong_pkg::coord_t pixel_y_i,
    sprite_if.display_mp     sprite_i,
    output logic             on_sprite_o,
    output pong_pkg::rgb_t   display_rgb_o
);

    logic [10:0] x_end;    // One bit wider so a sprite near the edge does not wrap
    logic [10:0] y_end;
    logic        hit;

    assign x_end = {1'b0, sprite_i.x} + 11'(WIDTH);
    assign y_end = {1'b0, sprite_i.y} + 11'(HEIGHT);

    assign hit = sprite_i.enable &&
                 pixel_x_i >= sprite_i.x && {1'b0, pixel_x_i} < x_end &&
                 pixel_y_i >= sprite_i.y && {1'b0, pixel_y_i} < y_end;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            on_sprite_o <= 1'b0;
        end else begin
            on_sprite_o <= hit;
        end
    end

    always_ff @(posedge clk_i) begin
        display_rgb_o <= sprite_i.color;    // Travels with the hit
    end

endmodule

//--- source/sprite_if.sv
`timescale 1ns/10ps

// Live attributes of one sprite
interface sprite_if;

    pong_pkg::coord_t x;
    pong_pkg::coord_t y;
    pong_pkg::rgb_t   color;
    logic             enable;

    modport regs_mp (
        output x, y, color, enable
    );

    modport display_mp (
        input x, y, color, enable
    );

endinterface

//--- source/sprite_regs.sv
`timescale 1ns/10ps
`include "pong_consts.svh"

module sprite_regs (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                req_i,
    input  pong_pkg::reg_addr_e addr_i,
    input  logic [11:0]         data_i,
    input  logic                new_frame_i,
    output logic                ack_o,
    sprite_if.regs_mp           sprites_o [`N_SPRITES],
    output pong_pkg::digit_t    score_l_o,
    output pong_pkg::digit_t    score_r_o
);

    localparam pong_pkg::coord_t RST_X [`N_SPRITES] = '{`LPAD_X0, `RPAD_X0, `BALL_X0};
    localparam pong_pkg::coord_t RST_Y [`N_SPRITES] = '{`LPAD_Y0, `RPAD_Y0, `BALL_Y0};

    pong_pkg::hs_state_e state;
    logic                write_en;
    pong_pkg::digit_t    score_clamped;

    pong_pkg::coord_t    shadow_x   [`N_SPRITES];
    pong_pkg::coord_t    shadow_y   [`N_SPRITES];
    pong_pkg::rgb_t      shadow_rgb [`N_SPRITES];
    logic                shadow_en  [`N_SPRITES];
    pong_pkg::digit_t    shadow_score_l;
    pong_pkg::digit_t    shadow_score_r;

    pong_pkg::coord_t    live_x   [`N_SPRITES];
    pong_pkg::coord_t    live_y   [`N_SPRITES];
    pong_pkg::rgb_t      live_rgb [`N_SPRITES];
    logic                live_en  [`N_SPRITES];

    assign write_en      = (state == pong_pkg::HS_IDLE) && req_i;
    assign ack_o         = (state == pong_pkg::HS_ACK);
    assign score_clamped = (data_i > 12'd9) ? 4'd9 : data_i[3:0];

    // Four-phase handshake, ack stays up until req is seen low
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state <= pong_pkg::HS_IDLE;
        end else begin
            case (state)
                pong_pkg::HS_IDLE: if (req_i) state <= pong_pkg::HS_ACK;
                pong_pkg::HS_ACK:  if (!req_i) state <= pong_pkg::HS_IDLE;
                default:           state <= pong_pkg::HS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int s = 0; s < `N_SPRITES; s++) begin
                shadow_x[s]   <= RST_X[s];
                shadow_y[s]   <= RST_Y[s];
                shadow_rgb[s] <= `SPRITE_RGB;
                shadow_en[s]  <= 1'b1;
            end
            shadow_score_l <= '0;
            shadow_score_r <= '0;
        end else if (write_en) begin
            case (addr_i)
                pong_pkg::ADDR_S0_X, pong_pkg::ADDR_S1_X, pong_pkg::ADDR_S2_X:
                    shadow_x[addr_i[3:2]] <= data_i[9:0];
                pong_pkg::ADDR_S0_Y, pong_pkg::ADDR_S1_Y, pong_pkg::ADDR_S2_Y:
                    shadow_y[addr_i[3:2]] <= data_i[9:0];
                pong_pkg::ADDR_S0_COLOR, pong_pkg::ADDR_S1_COLOR, pong_pkg::ADDR_S2_COLOR:
                    shadow_rgb[addr_i[3:2]] <= data_i;
                pong_pkg::ADDR_S0_EN, pong_pkg::ADDR_S1_EN, pong_pkg::ADDR_S2_EN:
                    shadow_en[addr_i[3:2]] <= data_i[0];
                pong_pkg::ADDR_SCORE_L: shadow_score_l <= score_clamped;
                pong_pkg::ADDR_SCORE_R: shadow_score_r <= score_clamped;
                default: ;    // Codes 14 and 15 are acknowledged and dropped
            endcase
        end
    end

    // Renderers only ever see a whole frame's worth of settings
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int s = 0; s < `N_SPRITES; s++) begin
                live_x[s]   <= RST_X[s];
                live_y[s]   <= RST_Y[s];
                live_rgb[s] <= `SPRITE_RGB;
                live_en[s]  <= 1'b1;
            end
            score_l_o <= '0;
            score_r_o <= '0;
        end else if (new_frame_i) begin
            live_x    <= shadow_x;
            live_y    <= shadow_y;
            live_rgb  <= shadow_rgb;
            live_en   <= shadow_en;
            score_l_o <= shadow_score_l;
            score_r_o <= shadow_score_r;
        end
    end

    for (genvar g = 0; g < `N_SPRITES; g++) begin : g_sprite_out
        assign sprites_o[g].x      = live_x[g];
        assign sprites_o[g].y      = live_y[g];
        assign sprites_o[g].color  = live_rgb[g];
        assign sprites_o[g].enable = live_en[g];
    end

endmodule

//--- source/vga_timing.sv
`timescale 1ns/10ps
`include "pong_consts.svh"

module vga_timing (
    input  logic             clk_i,
    input  logic             rst_i,
    output pong_pkg::coord_t pixel_x_o,
    output pong_pkg::coord_t pixel_y_o,
    output logic             hsync_o,
    output logic             vsync_o,
    output logic             visible_o
);

    logic h_last;
    logic v_last;

    assign h_last = (pixel_x_o == pong_pkg::coord_t'(`H_TOTAL - 1));
    assign v_last = (pixel_y_o == pong_pkg::coord_t'(`V_TOTAL - 1));

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pixel_x_o <= '0;
        end else if (h_last) begin
            pixel_x_o <= '0;
        end else begin
            pixel_x_o <= pixel_x_o + 1'b1;
        end
    end

    // Line counter steps at the end of every line
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pixel_y_o <= '0;
        end else if (h_last) begin
            if (v_last) begin
                pixel_y_o <= '0;
            end else begin
                pixel_y_o <= pixel_y_o + 1'b1;
            end
        end
    end

    // Both syncs are active low
    assign hsync_o = !(pixel_x_o >= `H_VISIBLE + `H_FRONT &&
                       pixel_x_o <  `H_VISIBLE + `H_FRONT + `H_SYNC);
    assign vsync_o = !(pixel_y_o >= `V_VISIBLE + `V_FRONT &&
                       pixel_y_o <  `V_VISIBLE + `V_FRONT + `V_SYNC);

    assign visible_o = (pixel_x_o < `H_VISIBLE) && (pixel_y_o < `V_VISIBLE);

endmodule

//--- tb.f
+incdir+source
source/pong_pkg.sv
source/sprite_if.sv
source/vga_timing.sv
source/sprite_display.sv
source/score_display.sv
source/frame_compositor.sv
source/sprite_regs.sv
source/pong_display_top.sv
sim/tb_pong_display.sv
